// File: Makefile
# Verilator build and run of the trellis front end testbench

TOP := trellisFrontEnd_tb
BIN := obj_dir/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): sources.f $(wildcard design/*.sv design/*.svh sim/*.sv)
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)

# the run passes only if the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	verilator --lint-only -Wall --timing --assert -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: design/dacOutputMux.sv
// ------------------------------
// three monitor channels, registered every clock
// sync is sym2xEn one cycle late, on every channel
// selects may change at any time and act on the next clock
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "trellisFront_consts.svh"

module dacOutputMux
   import trellisFrontPkg::*;
(
   input  logic                 clk,
   input  logic                 rstN,
   input  logic                 sym2xEn,
   input  cplxSample_t          scaledSample,
   input  logic [`TF_PHQ_W-1:0] phErrQ,
   input  dacSel_e              dac0Select,
   input  dacSel_e              dac1Select,
   input  dacSel_e              dac2Select,
   output dacOut_t              dac0,
   output dacOut_t              dac1,
   output dacOut_t              dac2
);

   // zero fill below the phase error
   localparam int PadW = `TF_SAMPLE_W - `TF_PHQ_W;

   // ------------------------------
   // source decode
   // ------------------------------
   // one decode for all channels
   // code 3 lands in the default arm
   function automatic logic [`TF_SAMPLE_W-1:0] dacSource(
      input dacSel_e              sel,
      input cplxSample_t          smp,
      input logic [`TF_PHQ_W-1:0] ph
   );
      case (sel)
         DAC_SEL_I: begin
            dacSource = smp.re;
         end
         DAC_SEL_Q: begin
            dacSource = smp.im;
         end
         default: begin
            // phase error left aligned in the dac word
            dacSource = {ph, {PadW{1'b0}}};
         end
      endcase
   endfunction

   // ------------------------------
   // output registers
   // ------------------------------
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         dac0 <= '0;
         dac1 <= '0;
         dac2 <= '0;
      end else begin
         dac0 <= '{sync: sym2xEn, data: dacSource(dac0Select, scaledSample, phErrQ)};
         dac1 <= '{sync: sym2xEn, data: dacSource(dac1Select, scaledSample, phErrQ)};
         dac2 <= '{sync: sym2xEn, data: dacSource(dac2Select, scaledSample, phErrQ)};
      end
   end

endmodule

`default_nettype wire

// File: design/phaseErrorQuantizer.sv
// ------------------------------
// 10 to 8 bit saturating scale of the trellis phase error
// result for strobe k is valid after strobe k+1
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "trellisFront_consts.svh"

module phaseErrorQuantizer (
   input  logic                   clk,
   input  logic                   rstN,
   input  logic                   sym2xEn,
   input  logic [`TF_PHERR_W-1:0] phaseError,
   output logic [`TF_PHQ_W-1:0]   phErrQ
);

   // lowest bit of the range check, also top bit kept
   localparam int HeadLsb = `TF_PHQ_W - 3;

   logic                 sign;
   logic [`TF_PHQ_W-1:0] dataBits;
   logic                 satPos;
   logic                 satNeg;

   assign sign = phaseError[`TF_PHERR_W-1];

   // stage 1 range check, stage 2 clip
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         dataBits <= '0;
         satPos   <= 1'b0;
         satNeg   <= 1'b0;
         phErrQ   <= '0;
      end else if (sym2xEn) begin
         // times four, low bits zero filled
         dataBits <= {phaseError[HeadLsb:0], 2'b00};
         satPos   <= !sign && (phaseError[`TF_PHERR_W-1:HeadLsb] != '0);
         satNeg   <= sign && (phaseError[`TF_PHERR_W-1:HeadLsb] != '1);
         if (satPos) begin
            phErrQ <= `TF_PHQ_POS;
         end else if (satNeg) begin
            phErrQ <= `TF_PHQ_NEG;
         end else begin
            phErrQ <= dataBits;
         end
      end
   end

endmodule

`default_nettype wire

// File: design/rotationBank.sv
// ------------------------------
// zero branch alignment and quarter-turn rotations
// scaledSample is sampled on each strobe, rotZ updates on the strobe
// negation wraps at TF_ROT_W bits, so the most negative code maps to itself
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "trellisFront_consts.svh"

module rotationBank
   import trellisFrontPkg::*;
(
   input  logic            clk,
   input  logic            rstN,
   input  logic            sym2xEn,
   input  cplxSample_t     scaledSample,
   output rotPoint_t [3:0] rotZ
);

   // zero branch shift register, index 0 is the newest
   cplxSample_t [`TF_ZERO_DELAY-1:0] zeroSr;
   cplxSample_t                      zTail;

   // halved tail and its negations
   logic signed [`TF_ROT_W-1:0] halfI;
   logic signed [`TF_ROT_W-1:0] halfQ;
   logic signed [`TF_ROT_W-1:0] negI;
   logic signed [`TF_ROT_W-1:0] negQ;

   assign zTail = zeroSr[`TF_ZERO_DELAY-1];

   // ------------------------------
   // halving truncation
   // ------------------------------
   // sign repeated once then the top bits
   // same as an arithmetic shift right by nine
   assign halfI = {zTail.re[`TF_SAMPLE_W-1], zTail.re[`TF_SAMPLE_W-1 -: `TF_ROT_W-1]};
   assign halfQ = {zTail.im[`TF_SAMPLE_W-1], zTail.im[`TF_SAMPLE_W-1 -: `TF_ROT_W-1]};

   // two's complement, wraps at the rotation width
   assign negI = -halfI;
   assign negQ = -halfQ;

   // ------------------------------
   // delay line and rotation registers
   // ------------------------------
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         zeroSr <= '0;
         rotZ   <= '0;
      end else if (sym2xEn) begin
         // keeps the zero branch lined up with the old filter latency
         zeroSr <= {zeroSr[`TF_ZERO_DELAY-2:0], scaledSample};
         // rot0 is z itself
         rotZ[0] <= '{re: halfI, im: halfQ};
         // rot1 turns by -90 degrees
         rotZ[1] <= '{re: halfQ, im: negI};
         // rot2 is the half turn
         rotZ[2] <= '{re: negI, im: negQ};
         // rot3 turns by +90 degrees
         rotZ[3] <= '{re: negQ, im: halfI};
      end
   end

endmodule

`default_nettype wire

// File: design/sampleScaler.sv
// ------------------------------
// times-two stage with symmetric clip on I and Q
// result for strobe k is valid after strobe k+1
// sym2xEn needs at least one idle cycle between strobes
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "trellisFront_consts.svh"

module sampleScaler
   import trellisFrontPkg::*;
(
   input  logic        clk,
   input  logic        rstN,
   input  logic        sym2xEn,
   input  cplxSample_t sampleIn,
   output cplxSample_t scaledSample
);

   // component 0 is I, component 1 is Q
   logic [1:0][`TF_SAMPLE_W-1:0] compIn;
   logic [1:0][`TF_SAMPLE_W-1:0] dblReg;
   logic [1:0]                   satPosReg;
   logic [1:0]                   satNegReg;
   logic [1:0][`TF_SAMPLE_W-1:0] compOut;

   assign compIn[0] = sampleIn.re;
   assign compIn[1] = sampleIn.im;

   // ------------------------------
   // stage 1 doubles and flags overflow
   // stage 2 picks clip or doubled value
   // ------------------------------
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         dblReg    <= '0;
         satPosReg <= '0;
         satNegReg <= '0;
         compOut   <= '0;
      end else if (sym2xEn) begin
         for (int c = 0; c < 2; c++) begin
            // left shift drops the redundant sign bit
            dblReg[c]    <= {compIn[c][`TF_SAMPLE_W-2:0], 1'b0};
            // top two bits differ, so the doubled value overflows
            satPosReg[c] <= !compIn[c][`TF_SAMPLE_W-1] && compIn[c][`TF_SAMPLE_W-2];
            satNegReg[c] <= compIn[c][`TF_SAMPLE_W-1] && !compIn[c][`TF_SAMPLE_W-2];
            // flags and doubled value are from the previous strobe
            if (satPosReg[c]) begin
               compOut[c] <= `TF_SAT_POS;
            end else if (satNegReg[c]) begin
               compOut[c] <= `TF_SAT_NEG;
            end else begin
               compOut[c] <= dblReg[c];
            end
         end
      end
   end

   assign scaledSample = '{re: compOut[0], im: compOut[1]};

endmodule

`default_nettype wire

// File: design/trellisFrontEnd.sv
// ------------------------------
// SOQPSK trellis front end, sample in to branch inputs
// stages advance only on sym2xEn, no stall and no handshake
// sym2xEn needs at least 2 idle cycles between strobes
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "trellisFront_consts.svh"

module trellisFrontEnd
   import trellisFrontPkg::*;
(
   input  logic                   clk,
   input  logic                   rstN,
   input  logic                   sym2xEn,
   input  cplxSample_t            sampleIn,
   input  logic [`TF_PHERR_W-1:0] phaseError,
   input  dacSel_e                dac0Select,
   input  dacSel_e                dac1Select,
   input  dacSel_e                dac2Select,
   output cplxSample_t            scaledSample,
   output rotPoint_t [3:0]        rotZ,
   output logic [`TF_PHQ_W-1:0]   phErrQ,
   output dacOut_t                dac0,
   output dacOut_t                dac1,
   output dacOut_t                dac2
);

   // ------------------------------
   // sample path
   // ------------------------------
   // input k reaches scaledSample after strobe k+1
   sampleScaler u_sampleScaler (
      .clk          (clk),
      .rstN         (rstN),
      .sym2xEn      (sym2xEn),
      .sampleIn     (sampleIn),
      .scaledSample (scaledSample)
   );

   // input k reaches rotZ after strobe k+6
   rotationBank u_rotationBank (
      .clk          (clk),
      .rstN         (rstN),
      .sym2xEn      (sym2xEn),
      .scaledSample (scaledSample),
      .rotZ         (rotZ)
   );

   // ------------------------------
   // phase error and monitors
   // ------------------------------
   phaseErrorQuantizer u_phaseErrorQuantizer (
      .clk        (clk),
      .rstN       (rstN),
      .sym2xEn    (sym2xEn),
      .phaseError (phaseError),
      .phErrQ     (phErrQ)
   );

   // one clock behind its sources
   dacOutputMux u_dacOutputMux (
      .clk          (clk),
      .rstN         (rstN),
      .sym2xEn      (sym2xEn),
      .scaledSample (scaledSample),
      .phErrQ       (phErrQ),
      .dac0Select   (dac0Select),
      .dac1Select   (dac1Select),
      .dac2Select   (dac2Select),
      .dac0         (dac0),
      .dac1         (dac1),
      .dac2         (dac2)
   );

endmodule

`default_nettype wire

// File: design/trellisFrontPkg.sv
// ------------------------------
// shared types for the trellis front end
// sizes come from the consts header
// ------------------------------
`default_nettype none

`include "trellisFront_consts.svh"

package trellisFrontPkg;

   // ------------------------------
   // datapath types
   // ------------------------------
   // complex baseband sample, re in the upper bits
   typedef struct packed {
      logic signed [`TF_SAMPLE_W-1:0] re;
      logic signed [`TF_SAMPLE_W-1:0] im;
   } cplxSample_t;

   // one quarter-turn rotation of the zero branch
   typedef struct packed {
      logic signed [`TF_ROT_W-1:0] re;
      logic signed [`TF_ROT_W-1:0] im;
   } rotPoint_t;

   // ------------------------------
   // monitor types
   // ------------------------------
   // dac source select
   // code 3 has no name and decodes as phase error
   typedef enum logic [1:0] {
      DAC_SEL_I     = 2'd0,
      DAC_SEL_Q     = 2'd1,
      DAC_SEL_PHERR = 2'd2
   } dacSel_e;

   // one monitor channel
   // sync marks the cycle after a sym2xEn strobe
   typedef struct packed {
      logic                   sync;
      logic [`TF_SAMPLE_W-1:0] data;
   } dacOut_t;

endpackage

`default_nettype wire

// File: design/trellisFront_consts.svh
// ------------------------------
// widths, alignment depth and clip codes for the trellis front end
// clip codes are sized literals and must track the widths below
// ------------------------------
`ifndef TRELLISFRONT_CONSTS_SVH
`define TRELLISFRONT_CONSTS_SVH

// ------------------------------
// data widths
// ------------------------------
// complex sample component, Q1.17
`define TF_SAMPLE_W 18
// rotated branch input component
`define TF_ROT_W 10
// raw trellis phase error
`define TF_PHERR_W 10
// quantized phase error for the carrier loop
`define TF_PHQ_W 8

// zero branch alignment, in sym2xEn strobes
`define TF_ZERO_DELAY 4

// ------------------------------
// saturation codes
// ------------------------------
// doubling clip, symmetric about zero
`define TF_SAT_POS 18'h1FFFF
`define TF_SAT_NEG 18'h20001
// phase error clip, also symmetric
`define TF_PHQ_POS 8'h7F
`define TF_PHQ_NEG 8'h81

`endif

// File: sim/trellisFrontEnd_checker.sv
// ------------------------------
// dac sync timing and half-turn symmetry
// bound into every trellisFrontEnd instance
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "trellisFront_consts.svh"

module trellisFrontEnd_checker
   import trellisFrontPkg::*;
(
   input logic            clk,
   input logic            rstN,
   input logic            sym2xEn,
   input rotPoint_t [3:0] rotZ,
   input dacOut_t         dac0,
   input dacOut_t         dac1,
   input dacOut_t         dac2
);

   logic [2:0]           syncs;
   logic [`TF_ROT_W-1:0] negRe;
   logic [`TF_ROT_W-1:0] negIm;

   assign syncs = {dac2.sync, dac1.sync, dac0.sync};
   // wraps at the rotation width like the bank
   assign negRe = -rotZ[0].re;
   assign negIm = -rotZ[0].im;

   // every channel carries the strobe one cycle late
   syncFollowsStrobe: assert property (@(posedge clk) disable iff (!rstN)
      syncs == {3{$past(sym2xEn)}})
      else $error("dac sync does not follow sym2xEn by one cycle");

   syncLowInReset: assert property (@(posedge clk) !rstN |-> syncs == 3'b000)
      else $error("dac sync high while rstN is low");

   halfTurnIsNegation: assert property (@(posedge clk) disable iff (!rstN)
      rotZ[2].re == negRe && rotZ[2].im == negIm)
      else $error("rotZ[2] is not the negation of rotZ[0]");

endmodule

bind trellisFrontEnd trellisFrontEnd_checker u_trellisFrontEndChecker (
   .clk     (clk),
   .rstN    (rstN),
   .sym2xEn (sym2xEn),
   .rotZ    (rotZ),
   .dac0    (dac0),
   .dac1    (dac1),
   .dac2    (dac2)
);

`default_nettype wire

// File: sim/trellisFrontEnd_tb.sv
// ------------------------------
// testbench for the trellis front end
// one strobe every third cycle, inputs driven 1 ns after the rising edge
// outputs compared at the falling edge against reference models
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "trellisFront_consts.svh"

module trellisFrontEnd_tb
   import trellisFrontPkg::*;
();

   localparam int StrobesPerTest = 200;
   localparam int NumTests = 5;
   // three cycles per strobe, plus margin for reset and drain
   localparam int TimeoutCycles = NumTests * StrobesPerTest * 3 + 1000;

   logic                   clk;
   logic                   rstN;
   logic                   sym2xEn;
   cplxSample_t            sampleIn;
   logic [`TF_PHERR_W-1:0] phaseError;
   dacSel_e                dac0Select;
   dacSel_e                dac1Select;
   dacSel_e                dac2Select;
   cplxSample_t            scaledSample;
   rotPoint_t [3:0]        rotZ;
   logic [`TF_PHQ_W-1:0]   phErrQ;
   dacOut_t                dac0;
   dacOut_t                dac1;
   dacOut_t                dac2;
   logic                   outputsZero;

   int    seed;
   int    cycleCnt;
   int    strobeCnt;
   int    selCode;
   int    errCount;
   int    checkCount;
   logic  enAtEdge;
   string testName;
   // inputs by strobe index
   cplxSample_t            sampHist[$];
   logic [`TF_PHERR_W-1:0] phHist[$];
   // model of the dac sources, and what the dac registers saw last clock
   cplxSample_t            expScaled;
   logic [`TF_PHQ_W-1:0]   expPh;
   dacSel_e                pendSel[3];
   cplxSample_t            pendScaled;
   logic [`TF_PHQ_W-1:0]   pendPh;
   logic                   pendSync;
   logic                   pendValid;

   trellisFrontEnd u_trellisFrontEnd (
      .clk          (clk),
      .rstN         (rstN),
      .sym2xEn      (sym2xEn),
      .sampleIn     (sampleIn),
      .phaseError   (phaseError),
      .dac0Select   (dac0Select),
      .dac1Select   (dac1Select),
      .dac2Select   (dac2Select),
      .scaledSample (scaledSample),
      .rotZ         (rotZ),
      .phErrQ       (phErrQ),
      .dac0         (dac0),
      .dac1         (dac1),
      .dac2         (dac2)
   );

   assign outputsZero = ({scaledSample, rotZ, phErrQ, dac0, dac1, dac2} == '0);

   always #50 clk = ~clk;

   // ------------------------------
   // reference models
   // ------------------------------
   function automatic logic [`TF_SAMPLE_W-1:0] refDouble(input logic [`TF_SAMPLE_W-1:0] x);
      if (x[`TF_SAMPLE_W-1] == x[`TF_SAMPLE_W-2]) begin
         refDouble = x << 1;
      end else if (!x[`TF_SAMPLE_W-1]) begin
         refDouble = `TF_SAT_POS;
      end else begin
         refDouble = `TF_SAT_NEG;
      end
   endfunction

   // doubled input idx, zero before the first strobe
   function automatic cplxSample_t scaledOf(input int idx);
      cplxSample_t s;
      s = '0;
      if (idx >= 0) begin
         s.re = refDouble(sampHist[idx].re);
         s.im = refDouble(sampHist[idx].im);
      end
      scaledOf = s;
   endfunction

   // halve by arithmetic shift, then one quarter-turn
   function automatic rotPoint_t refRot(input cplxSample_t z, input int r);
      logic signed [`TF_SAMPLE_W-1:0] si;
      logic signed [`TF_SAMPLE_W-1:0] sq;
      logic [`TF_ROT_W-1:0]           zi;
      logic [`TF_ROT_W-1:0]           zq;
      si = z.re >>> (`TF_SAMPLE_W - `TF_ROT_W + 1);
      sq = z.im >>> (`TF_SAMPLE_W - `TF_ROT_W + 1);
      zi = si[`TF_ROT_W-1:0];
      zq = sq[`TF_ROT_W-1:0];
      case (r)
         0: refRot = '{re: zi, im: zq};
         1: refRot = '{re: zq, im: -zi};
         2: refRot = '{re: -zi, im: -zq};
         default: refRot = '{re: -zq, im: zi};
      endcase
   endfunction

   function automatic logic [`TF_PHQ_W-1:0] refQuant(input logic [`TF_PHERR_W-1:0] p);
      if (!p[9] && p[9:5] != 5'h00) begin
         refQuant = `TF_PHQ_POS;
      end else if (p[9] && p[9:5] != 5'h1F) begin
         refQuant = `TF_PHQ_NEG;
      end else begin
         refQuant = {p[5:0], 2'b00};
      end
   endfunction

   function automatic logic [`TF_SAMPLE_W-1:0] refDac(input dacSel_e sel,
      input cplxSample_t s, input logic [`TF_PHQ_W-1:0] q);
      if (sel == DAC_SEL_I) begin
         refDac = s.re;
      end else if (sel == DAC_SEL_Q) begin
         refDac = s.im;
      end else begin
         refDac = {q, 10'd0};
      end
   endfunction

   // mode 1 uses the full range, else 1 in 8 lands near a rail
   function automatic logic [`TF_SAMPLE_W-1:0] randomComponent(input int mode);
      int r;
      r = $random(seed);
      if (mode == 1) begin
         randomComponent = r[`TF_SAMPLE_W-1:0];
      end else if (r[2:0] == 3'd0) begin
         randomComponent = r[3] ? (`TF_SAT_POS - {14'd0, r[7:4]}) : (18'h20000 + {14'd0, r[7:4]});
      end else begin
         randomComponent = {r[16], r[16:0]};
      end
   endfunction

   // ------------------------------
   // strobe tracking and comparison
   // ------------------------------
   always @(posedge clk) begin
      enAtEdge <= sym2xEn && rstN;
      if (sym2xEn && rstN) begin
         strobeCnt <= strobeCnt + 1;
      end
      cycleCnt = cycleCnt + 1;
      if (cycleCnt >= TimeoutCycles) begin
         $display("timeout: run did not finish within %0d cycles", TimeoutCycles);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   always @(negedge clk) begin
      rotPoint_t rotExp;
      dacOut_t   dacAct[3];
      dacOut_t   dacExp;
      int        n;
      if (!rstN) begin
         checkCount++;
         if (outputsZero !== 1'b1) begin
            errCount++;
            $display("[ERROR] %s outputs in reset expected 0 actual %h %h %h %h", testName,
                     scaledSample, rotZ, phErrQ, {dac0, dac1, dac2});
         end
         expScaled = '0;
         expPh = '0;
         pendValid = 1'b0;
      end else begin
         // cycle after strobe n, pipeline outputs just moved
         if (enAtEdge) begin
            n = strobeCnt - 1;
            expScaled = scaledOf(n - 1);
            expPh = '0;
            if (n >= 1) begin
               expPh = refQuant(phHist[n - 1]);
            end
            checkCount += 6;
            if (scaledSample !== expScaled) begin
               errCount++;
               $display("[ERROR] %s scaledSample strobe %0d expected %h actual %h",
                        testName, n, expScaled, scaledSample);
            end
            if (phErrQ !== expPh) begin
               errCount++;
               $display("[ERROR] %s phErrQ strobe %0d expected %h actual %h",
                        testName, n, expPh, phErrQ);
            end
            for (int r = 0; r < 4; r++) begin
               rotExp = refRot(scaledOf(n - 6), r);
               if (rotZ[r] !== rotExp) begin
                  errCount++;
                  $display("[ERROR] %s rotZ[%0d] strobe %0d expected %h actual %h",
                           testName, r, n, rotExp, rotZ[r]);
               end
            end
         end
         // dac registers hold what they saw one clock ago
         if (pendValid) begin
            dacAct[0] = dac0;
            dacAct[1] = dac1;
            dacAct[2] = dac2;
            for (int c = 0; c < 3; c++) begin
               dacExp = '{sync: pendSync, data: refDac(pendSel[c], pendScaled, pendPh)};
               checkCount++;
               if (dacAct[c] !== dacExp) begin
                  errCount++;
                  $display("[ERROR] %s dac%0d expected %h actual %h",
                           testName, c, dacExp, dacAct[c]);
               end
            end
         end
         pendSel[0] = dac0Select;
         pendSel[1] = dac1Select;
         pendSel[2] = dac2Select;
         pendScaled = expScaled;
         pendPh = expPh;
         pendSync = sym2xEn;
         pendValid = 1'b1;
      end
   end

   // ------------------------------
   // stimulus
   // ------------------------------
   // dac mode spreads the three channels over all four codes
   task automatic stepSelects(input int mode);
      if (mode == 3) begin
         selCode++;
         dac0Select = dacSel_e'(selCode[1:0]);
         dac1Select = dacSel_e'(2'(selCode + 1));
         dac2Select = dacSel_e'(2'(selCode + 2));
      end
   endtask

   task automatic runTest(input string name, input int mode);
      int errBefore;
      int r;
      errBefore = errCount;
      testName = name;
      for (int i = 0; i < StrobesPerTest; i++) begin
         @(posedge clk);
         #1;
         sym2xEn = 1'b1;
         sampleIn = '{re: randomComponent(mode), im: randomComponent(mode)};
         r = $random(seed);
         // sweep covers both in-range ends and both overflow sides
         phaseError = (mode == 2) ? 10'(i * 5 + 3) : r[`TF_PHERR_W-1:0];
         sampHist.push_back(sampleIn);
         phHist.push_back(phaseError);
         stepSelects(mode);
         repeat (2) begin
            @(posedge clk);
            #1;
            sym2xEn = 1'b0;
            stepSelects(mode);
         end
      end
      $display("test %s done, %0d errors", name, errCount - errBefore);
   endtask

   initial begin
      clk = 1'b0;
      rstN = 1'b0;
      sym2xEn = 1'b0;
      sampleIn = '0;
      phaseError = '0;
      dac0Select = DAC_SEL_I;
      dac1Select = DAC_SEL_Q;
      dac2Select = DAC_SEL_PHERR;
      seed = 93;
      cycleCnt = 0;
      strobeCnt = 0;
      selCode = 0;
      errCount = 0;
      checkCount = 0;
      enAtEdge = 1'b0;
      pendValid = 1'b0;
      expScaled = '0;
      expPh = '0;
      testName = "reset";
      repeat (5) @(posedge clk);
      #1;
      rstN = 1'b1;
      // still clear a few cycles after release
      repeat (3) @(negedge clk);
      checkCount++;
      if (outputsZero !== 1'b1) begin
         errCount++;
         $display("[ERROR] reset outputs after release expected 0 actual %h %h %h",
                  scaledSample, rotZ, phErrQ);
      end
      $display("test reset done, %0d errors", errCount);
      runTest("scale", 0);
      runTest("rotate", 1);
      runTest("pherr", 2);
      runTest("dac", 3);
      repeat (8) @(posedge clk);
      $display("all tests done, %0d checks, %0d errors", checkCount, errCount);
      if (errCount == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sources.f
+incdir+design
design/trellisFrontPkg.sv
design/sampleScaler.sv
design/rotationBank.sv
design/phaseErrorQuantizer.sv
design/dacOutputMux.sv
design/trellisFrontEnd.sv
sim/trellisFrontEnd_checker.sv
sim/trellisFrontEnd_tb.sv
